//--- design/xbus_config.svh
`ifndef XBUS_CONFIG_SVH
`define XBUS_CONFIG_SVH

// Single registers
`define XBUS_INDEX_ADDR      16'h1008
`define XBUS_CONFIG_ADDR     16'h1009
`define XBUS_USER_ADDR       16'h100A
`define XBUS_SHARED_ADDR     16'h100B
`define XBUS_INDIRECT_ADDR   16'h100C

// Register blocks, four registers each
`define XBUS_RW_BASE         16'h1010
`define XBUS_RO_BASE         16'h1014
`define XBUS_WO_BASE         16'h1018
`define XBUS_BLOCK_REGS      4

// 256-byte memory window
`define XBUS_MEM_BASE        16'h1100

// Reset values
`define XBUS_INDEX_RESET     3'd1
`define XBUS_CONFIG_RESET    8'hF0
`define XBUS_SHARED_RD_VALUE 8'hA5
`define XBUS_RW_RESET        8'h5A
`define XBUS_RO_RESET        8'hA5

`endif

//--- design/xbus_pkg.sv
package xbus_pkg;

  // --------------------------------------------------------------------------
  // Internal bus types
  // --------------------------------------------------------------------------

  // Byte address, low bits of the AXI address
  typedef logic [15:0] xbus_addr_t;

  // One register byte
  typedef logic [7:0] xbus_data_t;

  // --------------------------------------------------------------------------
  // AXI4-Lite response
  // --------------------------------------------------------------------------

  // Only OKAY and SLVERR are ever returned
  typedef enum logic [1:0] {
    AXIL_OKAY   = 2'b00,
    AXIL_SLVERR = 2'b10
  } axil_resp_t;

endpackage

//--- design/xbus_if.sv
`timescale 1ns/1ps

// One bridge's view of the internal bus
interface xbus_master_if;
  import xbus_pkg::*;

  logic       request;
  xbus_addr_t addr;
  logic       read;
  logic       write;
  xbus_data_t wdata;
  logic       grant;
  xbus_data_t rdata;
  logic       error;

  modport master (
    output request, addr, read, write, wdata,
    input  grant, rdata, error
  );

  modport arbiter (
    input  request, addr, read, write, wdata,
    output grant, rdata, error
  );
endinterface

// Arbiter to register target
interface xbus_target_if;
  import xbus_pkg::*;

  logic       valid;
  xbus_addr_t addr;
  logic       read;
  logic       write;
  xbus_data_t wdata;
  xbus_data_t rdata;
  logic       error;

  modport arbiter (
    output valid, addr, read, write, wdata,
    input  rdata, error
  );

  modport target (
    input  valid, addr, read, write, wdata,
    output rdata, error
  );
endinterface

//--- design/xbus_arbiter.sv
`timescale 1ns/1ps

module xbus_arbiter (
  input  logic              xbus_clock,
  input  logic              xbus_reset,
  xbus_master_if.arbiter    m0,
  xbus_master_if.arbiter    m1,
  xbus_target_if.arbiter    tgt
);

  typedef enum logic [1:0] {
    ST_START,
    ST_ADDR,
    ST_DATA
  } arb_state_t;

  arb_state_t state_q;
  logic       sel_q;    // Winner of the last start phase, 1 means m1
  logic       busy;

  // --------------------------------------------------------------------------
  // Phase sequence: start, address, data
  // --------------------------------------------------------------------------
  always_ff @(posedge xbus_clock or posedge xbus_reset) begin
    if (xbus_reset) begin
      state_q <= ST_START;
      sel_q   <= 1'b0;
    end else begin
      case (state_q)
        ST_START: begin
          // Fixed priority, m0 first
          if (m0.request) begin
            sel_q   <= 1'b0;
            state_q <= ST_ADDR;
          end else if (m1.request) begin
            sel_q   <= 1'b1;
            state_q <= ST_ADDR;
          end
        end
        ST_ADDR: state_q <= ST_DATA;
        ST_DATA: state_q <= ST_START;
        default: state_q <= ST_START;
      endcase
    end
  end

  assign busy = (state_q != ST_START);

  // Grant spans address and data phase
  assign m0.grant = busy && !sel_q;
  assign m1.grant = busy && sel_q;

  // Winner's fields onto the target
  assign tgt.valid = (state_q == ST_ADDR);
  assign tgt.addr  = sel_q ? m1.addr  : m0.addr;
  assign tgt.read  = sel_q ? m1.read  : m0.read;
  assign tgt.write = sel_q ? m1.write : m0.write;
  assign tgt.wdata = sel_q ? m1.wdata : m0.wdata;

  // Registered target result goes back to the granted master only
  assign m0.rdata = m0.grant ? tgt.rdata : '0;
  assign m1.rdata = m1.grant ? tgt.rdata : '0;
  assign m0.error = m0.grant && tgt.error;
  assign m1.error = m1.grant && tgt.error;

endmodule

//--- design/axil_xbus_bridge.sv
`timescale 1ns/1ps

module axil_xbus_bridge (
  input  logic                 xbus_clock,
  input  logic                 xbus_reset,
  input  logic                 awvalid,
  output logic                 awready,
  input  logic [31:0]          awaddr,
  input  logic                 wvalid,
  output logic                 wready,
  input  logic [31:0]          wdata,
  output logic                 bvalid,
  input  logic                 bready,
  output xbus_pkg::axil_resp_t bresp,
  input  logic                 arvalid,
  output logic                 arready,
  input  logic [31:0]          araddr,
  output logic                 rvalid,
  input  logic                 rready,
  output logic [31:0]          rdata,
  output xbus_pkg::axil_resp_t rresp,
  xbus_master_if.master        bus
);
  import xbus_pkg::*;

  typedef enum logic [1:0] {
    BR_IDLE,
    BR_BUS,
    BR_RESP
  } br_state_t;

  br_state_t  state_q;
  logic       is_read_q;
  logic       data_phase_q;   // Address phase already seen
  logic       wr_accept;
  logic       rd_accept;
  logic       resp_taken;
  logic       bus_done;
  xbus_addr_t addr_q;
  xbus_data_t wdata_q;
  xbus_data_t rdata_q;
  logic       err_q;
  axil_resp_t resp;

  // --------------------------------------------------------------------------
  // AXI acceptance, write only with AW and W together
  // --------------------------------------------------------------------------
  assign wr_accept = (state_q == BR_IDLE) && awvalid && wvalid;
  assign rd_accept = (state_q == BR_IDLE) && !(awvalid && wvalid) && arvalid;

  assign awready = wr_accept;
  assign wready  = wr_accept;
  assign arready = rd_accept;

  // Second granted cycle is the data phase
  assign bus_done   = (state_q == BR_BUS) && bus.grant && data_phase_q;
  assign resp_taken = is_read_q ? rready : bready;

  always_ff @(posedge xbus_clock or posedge xbus_reset) begin
    if (xbus_reset) begin
      state_q      <= BR_IDLE;
      is_read_q    <= 1'b0;
      data_phase_q <= 1'b0;
    end else begin
      case (state_q)
        BR_IDLE: begin
          if (wr_accept) begin
            is_read_q <= 1'b0;
            state_q   <= BR_BUS;
          end else if (rd_accept) begin
            is_read_q <= 1'b1;
            state_q   <= BR_BUS;
          end
        end
        BR_BUS: begin
          if (bus_done) begin
            data_phase_q <= 1'b0;
            state_q      <= BR_RESP;
          end else if (bus.grant) begin
            data_phase_q <= 1'b1;
          end
        end
        BR_RESP: begin
          if (resp_taken)
            state_q <= BR_IDLE;
        end
        default: state_q <= BR_IDLE;
      endcase
    end
  end

  // Transaction payload and bus result
  always_ff @(posedge xbus_clock) begin
    if (wr_accept) begin
      addr_q  <= awaddr[$bits(xbus_addr_t)-1:0];
      wdata_q <= wdata[$bits(xbus_data_t)-1:0];
    end else if (rd_accept) begin
      addr_q  <= araddr[$bits(xbus_addr_t)-1:0];
    end
    if (bus_done) begin
      rdata_q <= bus.rdata;
      err_q   <= bus.error;
    end
  end

  // --------------------------------------------------------------------------
  // Internal bus request and AXI response
  // --------------------------------------------------------------------------
  assign bus.request = (state_q == BR_BUS);
  assign bus.addr    = addr_q;
  assign bus.read    = bus.request && is_read_q;
  assign bus.write   = bus.request && !is_read_q;
  assign bus.wdata   = wdata_q;

  assign resp   = err_q ? AXIL_SLVERR : AXIL_OKAY;
  assign bvalid = (state_q == BR_RESP) && !is_read_q;
  assign rvalid = (state_q == BR_RESP) && is_read_q;
  assign bresp  = resp;
  assign rresp  = resp;
  assign rdata  = {{(32 - $bits(xbus_data_t)){1'b0}}, rdata_q};

endmodule

//--- design/xbus_reg_file.sv
`timescale 1ns/1ps
`include "xbus_config.svh"

module xbus_reg_file (
  input  logic          xbus_clock,
  input  logic          xbus_reset,
  xbus_target_if.target tgt
);
  import xbus_pkg::*;

  localparam int BLK_W         = $clog2(`XBUS_BLOCK_REGS);
  localparam int INDIRECT_REGS = 8;
  localparam int MEM_BYTES     = 256;

  // Control registers
  logic [2:0] index_q;
  xbus_data_t config_q;
  xbus_data_t user_q;
  xbus_data_t indirect_q [INDIRECT_REGS];
  xbus_data_t rw_q [`XBUS_BLOCK_REGS];

  // Memory window
  xbus_data_t mem [MEM_BYTES];

  xbus_data_t rdata_q;
  logic       error_q;

  logic is_index, is_config, is_user, is_shared, is_indirect;
  logic in_rw, in_ro, in_wo, in_mem;
  logic hit;
  logic wr_en;
  logic [BLK_W-1:0] blk_idx;
  logic [7:0]       mem_idx;
  xbus_data_t       rd_value;

  // --------------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------------
  assign is_index    = (tgt.addr == `XBUS_INDEX_ADDR);
  assign is_config   = (tgt.addr == `XBUS_CONFIG_ADDR);
  assign is_user     = (tgt.addr == `XBUS_USER_ADDR);
  assign is_shared   = (tgt.addr == `XBUS_SHARED_ADDR);
  assign is_indirect = (tgt.addr == `XBUS_INDIRECT_ADDR);

  assign in_rw  = (tgt.addr >= `XBUS_RW_BASE) &&
                  (tgt.addr < `XBUS_RW_BASE + `XBUS_BLOCK_REGS);
  assign in_ro  = (tgt.addr >= `XBUS_RO_BASE) &&
                  (tgt.addr < `XBUS_RO_BASE + `XBUS_BLOCK_REGS);
  assign in_wo  = (tgt.addr >= `XBUS_WO_BASE) &&
                  (tgt.addr < `XBUS_WO_BASE + `XBUS_BLOCK_REGS);
  assign in_mem = (tgt.addr >= `XBUS_MEM_BASE) &&
                  (tgt.addr < `XBUS_MEM_BASE + MEM_BYTES);

  // Aligned blocks let the low bits pick the register
  assign blk_idx = tgt.addr[BLK_W-1:0];
  assign mem_idx = tgt.addr[7:0];
  assign wr_en   = tgt.valid && tgt.write;

  // Read value and map hit
  always_comb begin
    hit      = 1'b1;
    rd_value = '0;
    if (is_index)
      rd_value = {5'b0, index_q};
    else if (is_config)
      rd_value = config_q;
    else if (is_user)
      rd_value = user_q;
    else if (is_shared)
      rd_value = `XBUS_SHARED_RD_VALUE;
    else if (is_indirect)
      rd_value = indirect_q[index_q];
    else if (in_rw)
      rd_value = rw_q[blk_idx];
    else if (in_ro)
      rd_value = `XBUS_RO_RESET;
    else if (in_wo)
      rd_value = '0;
    else if (in_mem)
      rd_value = mem[mem_idx];
    else
      hit = 1'b0;
  end

  // --------------------------------------------------------------------------
  // Writes at the end of the address phase and result for the data phase
  // --------------------------------------------------------------------------
  always_ff @(posedge xbus_clock or posedge xbus_reset) begin
    if (xbus_reset) begin
      index_q  <= `XBUS_INDEX_RESET;
      config_q <= `XBUS_CONFIG_RESET;
      user_q   <= '0;
      for (int i = 0; i < INDIRECT_REGS; i++)
        indirect_q[i] <= '0;
      for (int i = 0; i < `XBUS_BLOCK_REGS; i++)
        rw_q[i] <= `XBUS_RW_RESET;
      rdata_q  <= '0;
      error_q  <= 1'b0;
    end else if (tgt.valid) begin
      rdata_q <= tgt.read ? rd_value : '0;
      error_q <= !hit;
      if (tgt.write) begin
        if (is_index)
          index_q <= tgt.wdata[2:0];
        if (is_config)
          config_q <= tgt.wdata;
        // Counts writes and ignores the data
        if (is_user)
          user_q <= user_q + 8'd1;
        if (is_indirect)
          indirect_q[index_q] <= tgt.wdata;
        if (in_rw)
          rw_q[blk_idx] <= tgt.wdata;
      end
    end
  end

  // Shared and write-only writes are accepted and leave nothing to read back
  always_ff @(posedge xbus_clock) begin
    if (wr_en && in_mem)
      mem[mem_idx] <= tgt.wdata;
  end

  assign tgt.rdata = rdata_q;
  assign tgt.error = error_q;

endmodule

//--- design/xbus_subsystem.sv
`timescale 1ns/1ps

module xbus_subsystem (
  input  logic                 xbus_clock,
  input  logic                 xbus_reset,
  // AXI4-Lite port 0
  input  logic                 s0_awvalid,
  output logic                 s0_awready,
  input  logic [31:0]          s0_awaddr,
  input  logic                 s0_wvalid,
  output logic                 s0_wready,
  input  logic [31:0]          s0_wdata,
  output logic                 s0_bvalid,
  input  logic                 s0_bready,
  output xbus_pkg::axil_resp_t s0_bresp,
  input  logic                 s0_arvalid,
  output logic                 s0_arready,
  input  logic [31:0]          s0_araddr,
  output logic                 s0_rvalid,
  input  logic                 s0_rready,
  output logic [31:0]          s0_rdata,
  output xbus_pkg::axil_resp_t s0_rresp,
  // AXI4-Lite port 1
  input  logic                 s1_awvalid,
  output logic                 s1_awready,
  input  logic [31:0]          s1_awaddr,
  input  logic                 s1_wvalid,
  output logic                 s1_wready,
  input  logic [31:0]          s1_wdata,
  output logic                 s1_bvalid,
  input  logic                 s1_bready,
  output xbus_pkg::axil_resp_t s1_bresp,
  input  logic                 s1_arvalid,
  output logic                 s1_arready,
  input  logic [31:0]          s1_araddr,
  output logic                 s1_rvalid,
  input  logic                 s1_rready,
  output logic [31:0]          s1_rdata,
  output xbus_pkg::axil_resp_t s1_rresp
);

  xbus_master_if m0_bus ();
  xbus_master_if m1_bus ();
  xbus_target_if tgt_bus ();

  axil_xbus_bridge u_bridge0 (
    .xbus_clock (xbus_clock),  .xbus_reset (xbus_reset),
    .awvalid    (s0_awvalid),  .awready    (s0_awready),  .awaddr (s0_awaddr),
    .wvalid     (s0_wvalid),   .wready     (s0_wready),   .wdata  (s0_wdata),
    .bvalid     (s0_bvalid),   .bready     (s0_bready),   .bresp  (s0_bresp),
    .arvalid    (s0_arvalid),  .arready    (s0_arready),  .araddr (s0_araddr),
    .rvalid     (s0_rvalid),   .rready     (s0_rready),   .rdata  (s0_rdata),
    .rresp      (s0_rresp),    .bus        (m0_bus)
  );

  axil_xbus_bridge u_bridge1 (
    .xbus_clock (xbus_clock),  .xbus_reset (xbus_reset),
    .awvalid    (s1_awvalid),  .awready    (s1_awready),  .awaddr (s1_awaddr),
    .wvalid     (s1_wvalid),   .wready     (s1_wready),   .wdata  (s1_wdata),
    .bvalid     (s1_bvalid),   .bready     (s1_bready),   .bresp  (s1_bresp),
    .arvalid    (s1_arvalid),  .arready    (s1_arready),  .araddr (s1_araddr),
    .rvalid     (s1_rvalid),   .rready     (s1_rready),   .rdata  (s1_rdata),
    .rresp      (s1_rresp),    .bus        (m1_bus)
  );

  // Port 0 has priority on the internal bus
  xbus_arbiter u_arbiter (
    .xbus_clock (xbus_clock),
    .xbus_reset (xbus_reset),
    .m0         (m0_bus),
    .m1         (m1_bus),
    .tgt        (tgt_bus)
  );

  xbus_reg_file u_reg_file (
    .xbus_clock (xbus_clock),
    .xbus_reset (xbus_reset),
    .tgt        (tgt_bus)
  );

endmodule

//--- tb/tb_xbus_tasks.svh
`ifndef TB_XBUS_TASKS_SVH
`define TB_XBUS_TASKS_SVH

// ----------------------------------------------------------------------------
// Random numbers
// ----------------------------------------------------------------------------
function automatic logic [31:0] next_random();
  rng = rng ^ (rng << 13);
  rng = rng ^ (rng >> 17);
  rng = rng ^ (rng << 5);
  return rng;
endfunction

// Always ready unless back-pressure is wanted
function automatic logic ready_bit(input bit rand_ready);
  logic [31:0] r;
  r = next_random();
  return !rand_ready || r[0];
endfunction

// ----------------------------------------------------------------------------
// Register map model
// ----------------------------------------------------------------------------
xbus_data_t model_regs [xbus_addr_t];   // Readable bytes including memory once written
xbus_data_t model_indirect [8];

function automatic bit in_block(input xbus_addr_t addr, input xbus_addr_t base);
  return (addr >= base) && (addr < base + 16'(`XBUS_BLOCK_REGS));
endfunction

function automatic bit in_map(input xbus_addr_t addr);
  return (addr >= `XBUS_INDEX_ADDR && addr <= `XBUS_INDIRECT_ADDR) ||
         in_block(addr, `XBUS_RW_BASE) || in_block(addr, `XBUS_RO_BASE) ||
         in_block(addr, `XBUS_WO_BASE) ||
         (addr >= `XBUS_MEM_BASE && addr <= `XBUS_MEM_BASE + 16'hFF);
endfunction

function automatic void model_reset();
  model_regs.delete();
  model_regs[`XBUS_INDEX_ADDR]  = {5'b0, `XBUS_INDEX_RESET};
  model_regs[`XBUS_CONFIG_ADDR] = `XBUS_CONFIG_RESET;
  model_regs[`XBUS_USER_ADDR]   = 8'h00;
  for (int i = 0; i < `XBUS_BLOCK_REGS; i++)
    model_regs[`XBUS_RW_BASE + 16'(i)] = `XBUS_RW_RESET;
  for (int i = 0; i < 8; i++)
    model_indirect[i] = 8'h00;
endfunction

// Updates the model and returns the expected B response
function automatic axil_resp_t expect_write(input xbus_addr_t addr, input xbus_data_t data);
  xbus_data_t index_val;
  if (!in_map(addr))
    return AXIL_SLVERR;
  index_val = model_regs[`XBUS_INDEX_ADDR];
  if (addr == `XBUS_INDEX_ADDR)
    model_regs[addr] = {5'b0, data[2:0]};
  else if (addr == `XBUS_USER_ADDR)
    model_regs[addr] = model_regs[addr] + 8'd1;
  else if (addr == `XBUS_INDIRECT_ADDR)
    model_indirect[index_val[2:0]] = data;
  else if (addr == `XBUS_CONFIG_ADDR || in_block(addr, `XBUS_RW_BASE) ||
           addr >= `XBUS_MEM_BASE)
    model_regs[addr] = data;
  // Shared, read-only and write-only leave nothing readable
  return AXIL_OKAY;
endfunction

// Expected read byte with known low for memory never written
function automatic axil_resp_t expect_read(input xbus_addr_t addr, output xbus_data_t data,
                                           output bit known);
  xbus_data_t index_val;
  data  = 8'h00;
  known = 1'b1;
  if (!in_map(addr))
    return AXIL_SLVERR;
  index_val = model_regs[`XBUS_INDEX_ADDR];
  if (addr == `XBUS_SHARED_ADDR)
    data = `XBUS_SHARED_RD_VALUE;
  else if (addr == `XBUS_INDIRECT_ADDR)
    data = model_indirect[index_val[2:0]];
  else if (in_block(addr, `XBUS_RO_BASE))
    data = `XBUS_RO_RESET;
  else if (model_regs.exists(addr))
    data = model_regs[addr];
  else if (addr >= `XBUS_MEM_BASE)
    known = 1'b0;
  return AXIL_OKAY;
endfunction

// ----------------------------------------------------------------------------
// AXI4-Lite drivers
// ----------------------------------------------------------------------------
task automatic axi_write(input int port, input xbus_addr_t addr, input xbus_data_t data,
                         input bit rand_ready, output axil_resp_t resp);
  @(negedge xbus_clock);
  awvalid[port] = 1'b1;
  wvalid[port]  = 1'b1;
  awaddr[port]  = {16'h0000, addr};
  wdata[port]   = {24'h000000, data};
  #1;
  while (!(awready[port] || wready[port])) begin
    @(negedge xbus_clock);
    #1;
  end
  // AW and W are taken in the same cycle
  if (!(awready[port] && wready[port])) begin
    errors++;
    $display("Fail %0t: s%0d_awready/wready got %b/%b expected 1/1",
             $time, port, awready[port], wready[port]);
  end
  @(negedge xbus_clock);
  awvalid[port] = 1'b0;
  wvalid[port]  = 1'b0;
  bready[port]  = ready_bit(rand_ready);
  #1;
  while (!(bvalid[port] && bready[port])) begin
    @(negedge xbus_clock);
    bready[port] = ready_bit(rand_ready);
    #1;
  end
  resp = bresp[port];
  @(negedge xbus_clock);
  bready[port] = 1'b0;
endtask

task automatic axi_read(input int port, input xbus_addr_t addr, input bit rand_ready,
                        output logic [31:0] data, output axil_resp_t resp);
  @(negedge xbus_clock);
  arvalid[port] = 1'b1;
  araddr[port]  = {16'h0000, addr};
  #1;
  while (!arready[port]) begin
    @(negedge xbus_clock);
    #1;
  end
  @(negedge xbus_clock);
  arvalid[port] = 1'b0;
  rready[port]  = ready_bit(rand_ready);
  #1;
  while (!(rvalid[port] && rready[port])) begin
    @(negedge xbus_clock);
    rready[port] = ready_bit(rand_ready);
    #1;
  end
  data = rdata[port];
  resp = rresp[port];
  @(negedge xbus_clock);
  rready[port] = 1'b0;
endtask

// ----------------------------------------------------------------------------
// Compare tasks
// ----------------------------------------------------------------------------
task automatic check_data(input string name, input xbus_data_t got, input xbus_data_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("Fail %0t: %s got %02h expected %02h", $time, name, got, exp);
  end
endtask

task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("Fail %0t: %s got %b expected %b", $time, name, got, exp);
  end
endtask

task automatic write_and_check(input int port, input xbus_addr_t addr, input xbus_data_t data,
                               input bit rand_ready);
  axil_resp_t exp_resp;
  axil_resp_t resp;
  exp_resp = expect_write(addr, data);
  issued[port]++;
  axi_write(port, addr, data, rand_ready, resp);
  check_resp($sformatf("s%0d_bresp @%04h", port, addr), resp, exp_resp);
endtask

task automatic read_and_check(input int port, input xbus_addr_t addr, input bit rand_ready);
  logic [31:0] got;
  axil_resp_t  resp;
  axil_resp_t  exp_resp;
  xbus_data_t  exp;
  bit          known;
  issued[port]++;
  axi_read(port, addr, rand_ready, got, resp);
  exp_resp = expect_read(addr, exp, known);
  check_resp($sformatf("s%0d_rresp @%04h", port, addr), resp, exp_resp);
  if (known)
    check_data($sformatf("s%0d_rdata @%04h", port, addr), got[7:0], exp);
  if (got[31:8] !== 24'h000000) begin
    errors++;
    $display("Fail %0t: s%0d_rdata[31:8] @%04h got %06h expected 000000",
             $time, port, addr, got[31:8]);
  end
endtask

`endif

//--- tb/tb_xbus_subsystem.sv
`timescale 1ns/1ps
`include "xbus_config.svh"

module tb_xbus_subsystem;
  import xbus_pkg::*;

  localparam int N_RESET_READS = 17;
  localparam int N_REG_OPS     = 60;
  localparam int N_MEM_OPS     = 60;
  localparam int N_BAD_OPS     = 20;
  localparam int N_PAR_OPS     = 50;
  // Ports 0 and 1 both counted in full for the concurrent part
  localparam int TOTAL_OPS = N_RESET_READS + 2 * (N_REG_OPS + N_MEM_OPS + N_BAD_OPS)
                           + 2 * N_PAR_OPS;
  localparam int CYCLES_PER_OP = 40;

  logic        xbus_clock = 1'b0;
  logic        xbus_reset;
  logic [31:0] rng = 32'h7b81586b;
  int          errors = 0;
  int          checks = 0;
  int          issued [2] = '{0, 0};
  int          handshakes [2] = '{0, 0};

  // AXI4-Lite signals, index is the port number
  logic        awvalid [2];
  logic        awready [2];
  logic [31:0] awaddr  [2];
  logic        wvalid  [2];
  logic        wready  [2];
  logic [31:0] wdata   [2];
  logic        bvalid  [2];
  logic        bready  [2];
  axil_resp_t  bresp   [2];
  logic        arvalid [2];
  logic        arready [2];
  logic [31:0] araddr  [2];
  logic        rvalid  [2];
  logic        rready  [2];
  logic [31:0] rdata   [2];
  axil_resp_t  rresp   [2];

  `include "tb_xbus_tasks.svh"

  xbus_subsystem DUT (
    .xbus_clock (xbus_clock),  .xbus_reset (xbus_reset),
    .s0_awvalid (awvalid[0]),  .s0_awready (awready[0]),  .s0_awaddr (awaddr[0]),
    .s0_wvalid  (wvalid[0]),   .s0_wready  (wready[0]),   .s0_wdata  (wdata[0]),
    .s0_bvalid  (bvalid[0]),   .s0_bready  (bready[0]),   .s0_bresp  (bresp[0]),
    .s0_arvalid (arvalid[0]),  .s0_arready (arready[0]),  .s0_araddr (araddr[0]),
    .s0_rvalid  (rvalid[0]),   .s0_rready  (rready[0]),   .s0_rdata  (rdata[0]),
    .s0_rresp   (rresp[0]),
    .s1_awvalid (awvalid[1]),  .s1_awready (awready[1]),  .s1_awaddr (awaddr[1]),
    .s1_wvalid  (wvalid[1]),   .s1_wready  (wready[1]),   .s1_wdata  (wdata[1]),
    .s1_bvalid  (bvalid[1]),   .s1_bready  (bready[1]),   .s1_bresp  (bresp[1]),
    .s1_arvalid (arvalid[1]),  .s1_arready (arready[1]),  .s1_araddr (araddr[1]),
    .s1_rvalid  (rvalid[1]),   .s1_rready  (rready[1]),   .s1_rdata  (rdata[1]),
    .s1_rresp   (rresp[1])
  );

  always #5 xbus_clock = ~xbus_clock;

  // Completed B and R handshakes per port
  always @(posedge xbus_clock) begin
    for (int p = 0; p < 2; p++)
      if ((bvalid[p] && bready[p]) || (rvalid[p] && rready[p]))
        handshakes[p] <= handshakes[p] + 1;
  end

  // ----------------------------------------------------------------------------
  // Address pickers
  // ----------------------------------------------------------------------------
  function automatic xbus_addr_t reg_address();
    logic [31:0] r;
    r = next_random() % 17;
    if (r < 5)
      return `XBUS_INDEX_ADDR + 16'(r);
    return `XBUS_RW_BASE + 16'(r - 5);
  endfunction

  function automatic xbus_addr_t mem_address(input int unsigned lo, input int unsigned span);
    return `XBUS_MEM_BASE + 16'(lo) + 16'(next_random() % span);
  endfunction

  function automatic xbus_addr_t bad_address();
    xbus_addr_t addr;
    addr = 16'(next_random());
    while (in_map(addr))
      addr = 16'(next_random());
    return addr;
  endfunction

  // Port 0 on the RW block and low memory, port 1 on high memory
  task automatic parallel_traffic(input int port);
    xbus_addr_t  addr;
    logic [31:0] r;
    for (int i = 0; i < N_PAR_OPS; i++) begin
      r = next_random();
      if (port == 0 && r[1:0] == 2'd0)
        addr = `XBUS_RW_BASE + 16'(r[3:2]);
      else if (port == 0)
        addr = mem_address(0, 128);
      else
        addr = mem_address(128, 128);
      if (r[4])
        write_and_check(port, addr, r[15:8], 1'b1);
      else
        read_and_check(port, addr, 1'b1);
    end
  endtask

  // ----------------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------------
  initial begin
    xbus_reset = 1'b1;
    for (int p = 0; p < 2; p++) begin
      awvalid[p] = 1'b0;
      awaddr[p]  = '0;
      wvalid[p]  = 1'b0;
      wdata[p]   = '0;
      bready[p]  = 1'b0;
      arvalid[p] = 1'b0;
      araddr[p]  = '0;
      rready[p]  = 1'b0;
    end
    repeat (4) @(negedge xbus_clock);
    xbus_reset = 1'b0;
    model_reset();

    // Reset values of single registers and the three blocks
    for (int a = `XBUS_INDEX_ADDR; a <= `XBUS_INDIRECT_ADDR; a++)
      read_and_check(0, 16'(a), 1'b0);
    for (int a = `XBUS_RW_BASE; a < `XBUS_WO_BASE + `XBUS_BLOCK_REGS; a++)
      read_and_check(0, 16'(a), 1'b0);

    for (int i = 0; i < N_REG_OPS; i++) begin
      write_and_check(0, reg_address(), 8'(next_random()), 1'b0);
      read_and_check(0, reg_address(), 1'b0);
    end

    for (int i = 0; i < N_MEM_OPS; i++) begin
      write_and_check(0, mem_address(0, 256), 8'(next_random()), 1'b0);
      read_and_check(0, mem_address(0, 256), 1'b0);
    end

    // Unmapped addresses, alternating ports
    for (int i = 0; i < N_BAD_OPS; i++) begin
      write_and_check(i % 2, bad_address(), 8'(next_random()), 1'b0);
      read_and_check(i % 2, bad_address(), 1'b0);
    end

    fork
      parallel_traffic(0);
      parallel_traffic(1);
    join

    for (int p = 0; p < 2; p++) begin
      if (handshakes[p] != issued[p]) begin
        errors++;
        $display("Port %0d completed %0d responses for %0d transactions",
                 p, handshakes[p], issued[p]);
      end
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // Watchdog
  initial begin
    #(TOTAL_OPS * CYCLES_PER_OP * 10);
    $display("Run timed out after %0d cycles", TOTAL_OPS * CYCLES_PER_OP);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- list.f
+incdir+design
+incdir+tb
design/xbus_pkg.sv
design/xbus_if.sv
design/xbus_arbiter.sv
design/axil_xbus_bridge.sv
design/xbus_reg_file.sv
design/xbus_subsystem.sv
tb/tb_xbus_subsystem.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the xbus subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_xbus_subsystem

verilator --binary --timing -Wno-fatal -f list.f --top-module "$TOP" -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
  exit 1
fi
exit 0
